// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = bridgeTb
FILELIST  = compile.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: bench/bridgeChecker.sv
/* Scoreboard for l15Bridge, reads the DUT ports through bridgeTb.dut_i.
   Samples on the falling edge and assumes one L1.5 transaction in flight. */
`include "bridge_macros.svh"

module bridgeChecker (
  input  logic clk,
  input  logic rst_n,
  output int   errors_o
);

  import l15Pkg::*;
  import coreMemPkg::*;

  // accepted core request, misses keep their block address in addr
  typedef struct packed {
    l15ReqType_e                   kind;
    logic [`BRIDGE_ADDR_WIDTH-1:0] addr;
    logic [`BRIDGE_WORD_WIDTH-1:0] data;
    l15Size_e                      size;
  } coreTxn_t;

  coreTxn_t                         pending[$];
  coreTxn_t                         inflight;
  coreTxn_t                         txn;
  logic                             outstanding;
  logic                             wokeUp;
  logic                             expIc;
  logic                             expDc;
  logic                             expSt;
  logic                             expInv;
  invNotice_t                       expNotice;
  logic [`BRIDGE_IC_LINE_BITS-1:0]  lineTmp;

  // fill data rule: low address half, then pattern xor word number
  function automatic logic [63:0] fillWord(input logic [39:0] a, input int k);
    return {a[31:0], 32'h5A3C_C3A5 ^ k};
  endfunction

  // expected L1.5 request for a core request
  function automatic l15Req_t refReq(input coreTxn_t t);
    l15Req_t r;
    r = '0;
    r.reqType = t.kind;
    case (t.kind)
      LOAD: begin
        r.size = SZ_16B;
        r.addr = t.addr << 4;
      end
      IMISS: begin
        r.size = SZ_32B;
        r.addr = t.addr << 5;
      end
      default: begin
        r.size = t.size;
        r.addr = t.addr;
        r.data = t.data;
      end
    endcase
    return r;
  endfunction

  // expected fill line, word 0 low
  function automatic logic [255:0] refLine(input coreTxn_t t, input int words);
    logic [255:0] line;
    l15Req_t      req;
    line = '0;
    req  = refReq(t);
    for (int k = 0; k < words; k++) begin
      line[k*64 +: 64] = fillWord(req.addr, k);
    end
    return line;
  endfunction

  task automatic mismatch(input string name, input string exp, input string got);
    $display("CHECK FAILED t=%0t %s exp=%s got=%s", $time, name, exp, got);
    errors_o++;
  endtask

  task automatic problem(input string what);
    $display("error at t=%0t: %s", $time, what);
    errors_o++;
  endtask

  always @(negedge clk) begin
    if (!rst_n) begin
      pending.delete();
      outstanding = 1'b0;
      wokeUp      = 1'b0;
      expIc       = 1'b0;
      expDc       = 1'b0;
      expSt       = 1'b0;
      expInv      = 1'b0;
      errors_o    = 0;
    end else begin
      // core held in reset until the first INT_RET
      if (bridgeTb.dut_i.coreRstN_o !== wokeUp)
        mismatch("coreRstN_o", $sformatf("%b", wokeUp), $sformatf("%b", bridgeTb.dut_i.coreRstN_o));
      // return port never stalls
      if (bridgeTb.dut_i.l15RespAck_o !== bridgeTb.dut_i.l15RespVal_i)
        mismatch("l15RespAck_o", $sformatf("%b", bridgeTb.dut_i.l15RespVal_i),
                 $sformatf("%b", bridgeTb.dut_i.l15RespAck_o));
      // pulses expected one cycle after each return
      if (bridgeTb.dut_i.icFillVal_o !== expIc)
        mismatch("icFillVal_o", $sformatf("%b", expIc), $sformatf("%b", bridgeTb.dut_i.icFillVal_o));
      if (bridgeTb.dut_i.dcFillVal_o !== expDc)
        mismatch("dcFillVal_o", $sformatf("%b", expDc), $sformatf("%b", bridgeTb.dut_i.dcFillVal_o));
      if (bridgeTb.dut_i.stDone_o !== expSt)
        mismatch("stDone_o", $sformatf("%b", expSt), $sformatf("%b", bridgeTb.dut_i.stDone_o));
      if (bridgeTb.dut_i.invVal_o !== expInv)
        mismatch("invVal_o", $sformatf("%b", expInv), $sformatf("%b", bridgeTb.dut_i.invVal_o));
      if (bridgeTb.dut_i.invVal_o && bridgeTb.dut_i.invNotice_o !== expNotice)
        mismatch("invNotice_o", $sformatf("%h", expNotice), $sformatf("%h", bridgeTb.dut_i.invNotice_o));
      if (bridgeTb.dut_i.icFillVal_o) begin
        if (!outstanding || inflight.kind != IMISS) begin
          problem("icache fill without an outstanding instruction miss");
        end else begin
          lineTmp = refLine(inflight, 4);
          if (bridgeTb.dut_i.icFill_o !== {inflight.addr[34:0], lineTmp})
            mismatch("icFill_o", $sformatf("%h", {inflight.addr[34:0], lineTmp}),
                     $sformatf("%h", bridgeTb.dut_i.icFill_o));
        end
        outstanding = 1'b0;
      end
      if (bridgeTb.dut_i.dcFillVal_o) begin
        if (!outstanding || inflight.kind != LOAD) begin
          problem("dcache fill without an outstanding load miss");
        end else begin
          lineTmp = refLine(inflight, 2);
          if (bridgeTb.dut_i.dcFill_o !== {inflight.addr[35:0], lineTmp[127:0]})
            mismatch("dcFill_o", $sformatf("%h", {inflight.addr[35:0], lineTmp[127:0]}),
                     $sformatf("%h", bridgeTb.dut_i.dcFill_o));
        end
        outstanding = 1'b0;
      end
      if (bridgeTb.dut_i.stDone_o) begin
        if (!outstanding || inflight.kind != STORE)
          problem("store done without an outstanding store");
        outstanding = 1'b0;
      end
      // expectations for the next cycle
      expIc  = 1'b0;
      expDc  = 1'b0;
      expSt  = 1'b0;
      expInv = 1'b0;
      if (bridgeTb.dut_i.l15RespVal_i) begin
        expIc     = (bridgeTb.dut_i.l15Resp_i.retType == IFILL_RET);
        expDc     = (bridgeTb.dut_i.l15Resp_i.retType == LOAD_RET);
        expSt     = (bridgeTb.dut_i.l15Resp_i.retType == ST_ACK);
        expInv    = (bridgeTb.dut_i.l15Resp_i.retType == INV_RET);
        expNotice = {bridgeTb.dut_i.l15Resp_i.addr, bridgeTb.dut_i.l15Resp_i.icInval,
                     bridgeTb.dut_i.l15Resp_i.dcInval};
        if (bridgeTb.dut_i.l15Resp_i.retType == INT_RET)
          wokeUp = 1'b1;
      end
      if (bridgeTb.dut_i.l15ReqVal_o && outstanding)
        problem("L1.5 request raised while a transaction is outstanding");
      // fixed priority: load, store, instruction miss
      if ((bridgeTb.dut_i.icReqRdy_o && (bridgeTb.dut_i.dcLdReqVal_i || bridgeTb.dut_i.dcStReqVal_i))
          || (bridgeTb.dut_i.dcStReqRdy_o && bridgeTb.dut_i.dcLdReqVal_i))
        problem("core request accepted out of priority order");
      txn = '0;
      if (bridgeTb.dut_i.dcLdReqVal_i && bridgeTb.dut_i.dcLdReqRdy_o) begin
        txn.kind = LOAD;
        txn.addr = {4'b0, bridgeTb.dut_i.dcLdReq_i.blockAddr};
        pending.push_back(txn);
      end
      if (bridgeTb.dut_i.dcStReqVal_i && bridgeTb.dut_i.dcStReqRdy_o) begin
        txn.kind = STORE;
        txn.addr = bridgeTb.dut_i.dcStReq_i.addr;
        txn.data = bridgeTb.dut_i.dcStReq_i.data;
        txn.size = bridgeTb.dut_i.dcStReq_i.size;
        pending.push_back(txn);
      end
      if (bridgeTb.dut_i.icReqVal_i && bridgeTb.dut_i.icReqRdy_o) begin
        txn.kind = IMISS;
        txn.addr = {5'b0, bridgeTb.dut_i.icReq_i.blockAddr};
        pending.push_back(txn);
      end
      // request handshake, compare against the oldest accepted request
      if (bridgeTb.dut_i.l15ReqVal_o && bridgeTb.dut_i.l15ReqAck_i) begin
        if (pending.size() == 0) begin
          problem("L1.5 request with no accepted core request");
        end else begin
          inflight = pending.pop_front();
          if (bridgeTb.dut_i.l15Req_o !== refReq(inflight))
            mismatch("l15Req_o", $sformatf("%h", refReq(inflight)),
                     $sformatf("%h", bridgeTb.dut_i.l15Req_o));
        end
        outstanding = 1'b1;
      end
    end
  end

endmodule

// File: bench/bridgeTb.sv
/* Acts as the core and as the L1.5 around l15Bridge; checks sit in bridgeChecker.
   Ack and return delays are 0 to 7 cycles, drawn from a seeded LFSR. */
`include "bridge_macros.svh"

module bridgeTb;

  import l15Pkg::*;
  import coreMemPkg::*;

  logic        clk;
  logic        rst_n;
  logic        icReqVal_i, icReqRdy_o, dcLdReqVal_i, dcLdReqRdy_o;
  logic        dcStReqVal_i, dcStReqRdy_o;
  icMissReq_t  icReq_i;
  dcLoadReq_t  dcLdReq_i;
  dcStoreReq_t dcStReq_i;
  logic        icFillVal_o, dcFillVal_o, stDone_o, invVal_o, coreRstN_o;
  icFill_t     icFill_o;
  dcFill_t     dcFill_o;
  invNotice_t  invNotice_o;
  logic        l15ReqVal_o, l15ReqAck_i, l15RespVal_i, l15RespAck_o;
  l15Req_t     l15Req_o;
  l15Resp_t    l15Resp_i;
  logic [15:0] lfsr;
  logic [63:0] r;
  int          chkErrors;
  int          timeouts;

  l15Bridge dut_i (.*);

  bridgeChecker chk_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .errors_o (chkErrors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Fibonacci, taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic randBits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
  endtask

  function automatic logic [63:0] fillWord(input logic [39:0] a, input int k);
    return {a[31:0], 32'h5A3C_C3A5 ^ k};
  endfunction

  // L1.5 answer for an acked request
  function automatic l15Resp_t answer(input l15Req_t req);
    l15Resp_t resp;
    resp      = '0;
    resp.addr = req.addr;
    case (req.reqType)
      IMISS:   resp.retType = IFILL_RET;
      LOAD:    resp.retType = LOAD_RET;
      default: resp.retType = ST_ACK;
    endcase
    if (req.reqType != STORE) begin
      for (int k = 0; k < 4; k++) begin
        resp.data[k] = fillWord(req.addr, k);
      end
    end
    return resp;
  endfunction

  // one-cycle return, called just after a rising edge
  task automatic pulseReturn(input l15Resp_t resp);
    l15Resp_i    = resp;
    l15RespVal_i = 1'b1;
    @(posedge clk);
    #1;
    l15RespVal_i = 1'b0;
  endtask

  task automatic invalidate(input logic ic, input logic dc);
    l15Resp_t resp;
    randBits(40, r);
    resp         = '0;
    resp.retType = INV_RET;
    resp.addr    = r[39:0];
    resp.icInval = ic;
    resp.dcInval = dc;
    pulseReturn(resp);
  endtask

  // interrupt return that releases the core
  task automatic wakeCore();
    l15Resp_t resp;
    resp         = '0;
    resp.retType = INT_RET;
    pulseReturn(resp);
  endtask

  task automatic raiseIc();
    randBits(35, r);
    icReq_i.blockAddr = r[34:0];
    icReqVal_i        = 1'b1;
  endtask

  task automatic raiseLoad();
    randBits(36, r);
    dcLdReq_i.blockAddr = r[35:0];
    dcLdReqVal_i        = 1'b1;
  endtask

  task automatic raiseStore();
    randBits(40, r);
    dcStReq_i.addr = r[39:0];
    randBits(64, r);
    dcStReq_i.data = r;
    randBits(2, r);
    dcStReq_i.size = l15Size_e'({1'b0, r[1:0]});
    dcStReqVal_i   = 1'b1;
  endtask

  // core and L1.5 model, cycle by cycle until everything is quiet
  task automatic runTraffic();
    int          cyc;
    int          quiet;
    int          phase;
    logic [2:0]  delay;
    logic        accIc, accLd, accSt, ackSeen, reqSeen;
    l15Req_t     held;
    cyc   = 0;
    quiet = 0;
    phase = 0;
    delay = '0;
    while (quiet < 4 && cyc < 400) begin
      @(negedge clk);
      accIc   = icReqVal_i & icReqRdy_o;
      accLd   = dcLdReqVal_i & dcLdReqRdy_o;
      accSt   = dcStReqVal_i & dcStReqRdy_o;
      ackSeen = l15ReqVal_o & l15ReqAck_i;
      reqSeen = l15ReqVal_o;
      held    = l15Req_o;
      @(posedge clk);
      #1;
      cyc++;
      l15ReqAck_i  = 1'b0;
      l15RespVal_i = 1'b0;
      if (accIc) icReqVal_i = 1'b0;
      if (accLd) dcLdReqVal_i = 1'b0;
      if (accSt) dcStReqVal_i = 1'b0;
      if (ackSeen) begin
        randBits(3, r);
        delay = r[2:0];
        phase = 2;
        l15Resp_i = answer(held);
      end else if (phase == 0 && reqSeen) begin
        randBits(3, r);
        delay = r[2:0];
        phase = 1;
      end else if (phase == 1) begin
        if (delay == 0) l15ReqAck_i = 1'b1;
        else delay = delay - 1'b1;
      end else if (phase == 2) begin
        if (delay == 0) begin
          l15RespVal_i = 1'b1;
          phase        = 0;
        end else begin
          delay = delay - 1'b1;
        end
      end
      if (!icReqVal_i && !dcLdReqVal_i && !dcStReqVal_i && phase == 0 && !reqSeen && !l15RespVal_i)
        quiet++;
      else
        quiet = 0;
    end
    if (quiet < 4) begin
      $display("timeout at t=%0t: traffic did not drain within 400 cycles", $time);
      timeouts++;
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    // core valids high through reset, readies must stay low
    icReqVal_i   = 1'b1;
    dcLdReqVal_i = 1'b1;
    dcStReqVal_i = 1'b1;
    icReq_i      = '0;
    dcLdReq_i    = '0;
    dcStReq_i    = '0;
    l15ReqAck_i  = 1'b0;
    l15RespVal_i = 1'b0;
    l15Resp_i    = '0;
    lfsr         = 16'd19781;
    timeouts     = 0;
    repeat (5) @(posedge clk);
    #1;
    icReqVal_i   = 1'b0;
    dcLdReqVal_i = 1'b0;
    dcStReqVal_i = 1'b0;
    rst_n        = 1'b1;
    // core stays in reset through an invalidation, wakes on INT_RET
    invalidate(1'b1, 1'b0);
    wakeCore();
    raiseIc();
    runTraffic();
    raiseLoad();
    runTraffic();
    raiseStore();
    runTraffic();
    // all three at once
    raiseIc();
    raiseLoad();
    raiseStore();
    runTraffic();
    invalidate(1'b1, 1'b1);
    invalidate(1'b0, 1'b1);
    for (int i = 0; i < 8; i++) begin
      randBits(3, r);
      if (r[0]) raiseIc();
      if (r[1]) raiseLoad();
      if (r[2] || r[2:0] == 3'b000) raiseStore();
      runTraffic();
    end
    repeat (3) @(posedge clk);
    $display("done: %0d check errors, %0d timeouts", chkErrors, timeouts);
    if (chkErrors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: bench/bridge_assertions.sv
/* L1.5 request handshake checks, bound into every reqArbiter instance. */
module bridgeAssertions (
  input logic            clk,
  input logic            rst_n,
  input logic            icReqRdy_o,
  input logic            dcLdReqRdy_o,
  input logic            dcStReqRdy_o,
  input logic            txnDone_i,
  input logic            l15ReqVal_o,
  input logic            l15ReqAck_i,
  input l15Pkg::l15Req_t l15Req_o
);

  logic busy;

  // set by the ack, cleared by the return
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (l15ReqVal_o && l15ReqAck_i) begin
      busy <= 1'b1;
    end else if (txnDone_i) begin
      busy <= 1'b0;
    end
  end

  holdStable: assert property (@(posedge clk) disable iff (!rst_n)
    l15ReqVal_o && !l15ReqAck_i |=> l15ReqVal_o && $stable(l15Req_o))
    else $error("request dropped or changed before its ack");

  oneOutstanding: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !l15ReqVal_o)
    else $error("second request raised before the transaction finished");

  quietInReset: assert property (@(posedge clk)
    !rst_n |-> !(icReqRdy_o || dcLdReqRdy_o || dcStReqRdy_o))
    else $error("core ready high during reset");

endmodule

bind reqArbiter bridgeAssertions asrt_i (.*);

// File: compile.f
+incdir+source
source/l15Pkg.sv
source/coreMemPkg.sv
source/reqArbiter.sv
source/respRouter.sv
source/l15Bridge.sv
bench/bridge_assertions.sv
bench/bridgeChecker.sv
bench/bridgeTb.sv

// File: source/bridge_macros.svh
/* Widths shared by the bridge RTL and its packages.
   Line sizes are fixed: 32-byte icache lines, 16-byte dcache lines. */
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// physical address on the L1.5 side
`define BRIDGE_ADDR_WIDTH 40

// one L1.5 data word
`define BRIDGE_WORD_WIDTH 64

// full icache line, four words
`define BRIDGE_IC_LINE_BITS 256

// full dcache line, two words
`define BRIDGE_DC_LINE_BITS 128

// icache block address, 5 offset bits dropped
`define BRIDGE_IC_BLOCK_BITS (`BRIDGE_ADDR_WIDTH - 5)

// dcache block address, 4 offset bits dropped
`define BRIDGE_DC_BLOCK_BITS (`BRIDGE_ADDR_WIDTH - 4)

`endif

// File: source/coreMemPkg.sv
/* Core-side miss, store, fill and invalidation records.
   Block addresses carry no offset bits; store addresses are byte addresses. */
`include "bridge_macros.svh"

package coreMemPkg;

  // icache miss, one line per request
  typedef struct packed {
    logic [`BRIDGE_IC_BLOCK_BITS-1:0] blockAddr;
  } icMissReq_t;

  // dcache load miss
  typedef struct packed {
    logic [`BRIDGE_DC_BLOCK_BITS-1:0] blockAddr;
  } dcLoadReq_t;

  // store goes to the L1.5 as given
  typedef struct packed {
    logic [`BRIDGE_ADDR_WIDTH-1:0] addr;
    logic [`BRIDGE_WORD_WIDTH-1:0] data;
    l15Pkg::l15Size_e              size;
  } dcStoreReq_t;

  typedef struct packed {
    logic [`BRIDGE_IC_BLOCK_BITS-1:0] blockAddr;
    logic [`BRIDGE_IC_LINE_BITS-1:0]  line;
  } icFill_t;

  typedef struct packed {
    logic [`BRIDGE_DC_BLOCK_BITS-1:0] blockAddr;
    logic [`BRIDGE_DC_LINE_BITS-1:0]  line;
  } dcFill_t;

  // both flags may be set at once
  typedef struct packed {
    logic [`BRIDGE_ADDR_WIDTH-1:0] addr;
    logic                          icInval;
    logic                          dcInval;
  } invNotice_t;

endpackage

// File: source/l15Bridge.sv
/* Core held in reset (coreRstN_o low) until the first INT_RET from the L1.5.
   Core requests are served one at a time. */
module l15Bridge (
  input  logic                     clk,
  input  logic                     rst_n,
  // core request channels
  input  logic                     icReqVal_i,
  input  coreMemPkg::icMissReq_t   icReq_i,
  output logic                     icReqRdy_o,
  input  logic                     dcLdReqVal_i,
  input  coreMemPkg::dcLoadReq_t   dcLdReq_i,
  output logic                     dcLdReqRdy_o,
  input  logic                     dcStReqVal_i,
  input  coreMemPkg::dcStoreReq_t  dcStReq_i,
  output logic                     dcStReqRdy_o,
  // core returns
  output logic                     icFillVal_o,
  output coreMemPkg::icFill_t      icFill_o,
  output logic                     dcFillVal_o,
  output coreMemPkg::dcFill_t      dcFill_o,
  output logic                     stDone_o,
  output logic                     invVal_o,
  output coreMemPkg::invNotice_t   invNotice_o,
  output logic                     coreRstN_o,
  // L1.5 request side
  output logic                     l15ReqVal_o,
  output l15Pkg::l15Req_t          l15Req_o,
  input  logic                     l15ReqAck_i,
  // L1.5 return side
  input  logic                     l15RespVal_i,
  input  l15Pkg::l15Resp_t         l15Resp_i,
  output logic                     l15RespAck_o
);

  logic txnDone;
  logic wakeup;
  logic coreRun;

  reqArbiter arb (
    .clk          (clk),
    .rst_n        (rst_n),
    .icReqVal_i   (icReqVal_i),
    .icReq_i      (icReq_i),
    .icReqRdy_o   (icReqRdy_o),
    .dcLdReqVal_i (dcLdReqVal_i),
    .dcLdReq_i    (dcLdReq_i),
    .dcLdReqRdy_o (dcLdReqRdy_o),
    .dcStReqVal_i (dcStReqVal_i),
    .dcStReq_i    (dcStReq_i),
    .dcStReqRdy_o (dcStReqRdy_o),
    .txnDone_i    (txnDone),
    .l15ReqVal_o  (l15ReqVal_o),
    .l15Req_o     (l15Req_o),
    .l15ReqAck_i  (l15ReqAck_i)
  );

  respRouter router (
    .clk          (clk),
    .rst_n        (rst_n),
    .l15RespVal_i (l15RespVal_i),
    .l15Resp_i    (l15Resp_i),
    .l15RespAck_o (l15RespAck_o),
    .icFillVal_o  (icFillVal_o),
    .icFill_o     (icFill_o),
    .dcFillVal_o  (dcFillVal_o),
    .dcFill_o     (dcFill_o),
    .stDone_o     (stDone_o),
    .invVal_o     (invVal_o),
    .invNotice_o  (invNotice_o),
    .wakeup_o     (wakeup),
    .txnDone_o    (txnDone)
  );

  // sticky once the first wakeup arrives
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      coreRun <= 1'b0;
    end else if (wakeup) begin
      coreRun <= 1'b1;
    end
  end

  // wakeup pulse releases the core in the cycle after INT_RET
  assign coreRstN_o = coreRun | wakeup;

endmodule

// File: source/l15Pkg.sv
/* L1.5 request and return formats. Reduced to the fields this bridge uses
   (no thread id, nc, atomics, csm or way fields). */
`include "bridge_macros.svh"

package l15Pkg;

  // request opcodes, reduced to the three the bridge issues
  typedef enum logic [1:0] {
    LOAD  = 2'b00,
    IMISS = 2'b01,
    STORE = 2'b10
  } l15ReqType_e;

  // return opcodes, values follow the L1.5 return type field
  typedef enum logic [3:0] {
    LOAD_RET  = 4'b0000,
    IFILL_RET = 4'b0001,
    INV_RET   = 4'b0011,
    ST_ACK    = 4'b0100,
    INT_RET   = 4'b0111
  } l15RetType_e;

  // pcx style size codes, 32B placed in a spare code
  typedef enum logic [2:0] {
    SZ_1B  = 3'b000,
    SZ_2B  = 3'b001,
    SZ_4B  = 3'b010,
    SZ_8B  = 3'b011,
    SZ_32B = 3'b110,
    SZ_16B = 3'b111
  } l15Size_e;

  typedef struct packed {
    l15ReqType_e                  reqType;
    l15Size_e                     size;
    logic [`BRIDGE_ADDR_WIDTH-1:0] addr;
    // store data only, zero for misses
    logic [`BRIDGE_WORD_WIDTH-1:0] data;
  } l15Req_t;

  typedef struct packed {
    l15RetType_e                   retType;
    logic [`BRIDGE_ADDR_WIDTH-1:0] addr;
    logic                          icInval;
    logic                          dcInval;
    // word 0 sits in the low bits
    logic [3:0][`BRIDGE_WORD_WIDTH-1:0] data;
  } l15Resp_t;

endpackage

// File: source/reqArbiter.sv
/* One outstanding L1.5 transaction; priority is fixed, load > store > imiss.
   No timeout: a lost ack or return keeps the arbiter busy. */
`include "bridge_macros.svh"

module reqArbiter (
  input  logic                     clk,
  input  logic                     rst_n,
  // icache miss channel
  input  logic                     icReqVal_i,
  input  coreMemPkg::icMissReq_t   icReq_i,
  output logic                     icReqRdy_o,
  // dcache load miss channel
  input  logic                     dcLdReqVal_i,
  input  coreMemPkg::dcLoadReq_t   dcLdReq_i,
  output logic                     dcLdReqRdy_o,
  // store channel
  input  logic                     dcStReqVal_i,
  input  coreMemPkg::dcStoreReq_t  dcStReq_i,
  output logic                     dcStReqRdy_o,
  // return path finished the transaction
  input  logic                     txnDone_i,
  // L1.5 request port
  output logic                     l15ReqVal_o,
  output l15Pkg::l15Req_t          l15Req_o,
  input  logic                     l15ReqAck_i
);

  import l15Pkg::*;

  localparam int IcOffBits = `BRIDGE_ADDR_WIDTH - `BRIDGE_IC_BLOCK_BITS;
  localparam int DcOffBits = `BRIDGE_ADDR_WIDTH - `BRIDGE_DC_BLOCK_BITS;

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    WAIT
  } arbState_e;

  arbState_e state;
  arbState_e stateNext;
  l15Req_t   nextReq;
  logic      accept;

  // pick a winner and build its request while idle
  always_comb begin
    icReqRdy_o   = 1'b0;
    dcLdReqRdy_o = 1'b0;
    dcStReqRdy_o = 1'b0;
    nextReq      = '0;
    // readies held low in reset
    if (state == IDLE && rst_n) begin
      if (dcLdReqVal_i) begin
        dcLdReqRdy_o    = 1'b1;
        nextReq.reqType = LOAD;
        nextReq.size    = SZ_16B;
        // block address back to a line-aligned byte address
        nextReq.addr    = {dcLdReq_i.blockAddr, {DcOffBits{1'b0}}};
      end else if (dcStReqVal_i) begin
        dcStReqRdy_o    = 1'b1;
        nextReq.reqType = STORE;
        nextReq.size    = dcStReq_i.size;
        nextReq.addr    = dcStReq_i.addr;
        nextReq.data    = dcStReq_i.data;
      end else if (icReqVal_i) begin
        icReqRdy_o      = 1'b1;
        nextReq.reqType = IMISS;
        nextReq.size    = SZ_32B;
        nextReq.addr    = {icReq_i.blockAddr, {IcOffBits{1'b0}}};
      end
    end
  end

  assign accept = icReqRdy_o | dcLdReqRdy_o | dcStReqRdy_o;

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (accept) begin
          stateNext = SEND;
        end
      end
      // hold valid and payload until the L1.5 takes it
      SEND: begin
        if (l15ReqAck_i) begin
          stateNext = WAIT;
        end
      end
      // return not seen yet
      WAIT: begin
        if (txnDone_i) begin
          stateNext = IDLE;
        end
      end
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

  // payload captured once per accept, stable through SEND
  always_ff @(posedge clk) begin
    if (accept) begin
      l15Req_o <= nextReq;
    end
  end

  assign l15ReqVal_o = (state == SEND);

endmodule

// File: source/respRouter.sv
/* L1.5 returns are always acked in the same cycle; outputs are one-cycle pulses
   one clock later. Unknown return types are acked and dropped. */
`include "bridge_macros.svh"

module respRouter (
  input  logic                    clk,
  input  logic                    rst_n,
  // L1.5 return port
  input  logic                    l15RespVal_i,
  input  l15Pkg::l15Resp_t        l15Resp_i,
  output logic                    l15RespAck_o,
  // fills to the caches
  output logic                    icFillVal_o,
  output coreMemPkg::icFill_t     icFill_o,
  output logic                    dcFillVal_o,
  output coreMemPkg::dcFill_t     dcFill_o,
  // store completion
  output logic                    stDone_o,
  // invalidation notice
  output logic                    invVal_o,
  output coreMemPkg::invNotice_t  invNotice_o,
  // interrupt, releases the core reset
  output logic                    wakeup_o,
  // frees the request arbiter
  output logic                    txnDone_o
);

  import l15Pkg::*;

  localparam int IcOffBits = `BRIDGE_ADDR_WIDTH - `BRIDGE_IC_BLOCK_BITS;
  localparam int DcOffBits = `BRIDGE_ADDR_WIDTH - `BRIDGE_DC_BLOCK_BITS;

  logic isIfill;
  logic isLoad;
  logic isStAck;
  logic isInv;
  logic isInt;

  // never stalls the L1.5
  assign l15RespAck_o = l15RespVal_i;

  // opcode decode, qualified by valid
  always_comb begin
    isIfill = 1'b0;
    isLoad  = 1'b0;
    isStAck = 1'b0;
    isInv   = 1'b0;
    isInt   = 1'b0;
    if (l15RespVal_i) begin
      case (l15Resp_i.retType)
        IFILL_RET: isIfill = 1'b1;
        LOAD_RET:  isLoad  = 1'b1;
        ST_ACK:    isStAck = 1'b1;
        INV_RET:   isInv   = 1'b1;
        INT_RET:   isInt   = 1'b1;
        default: ;
      endcase
    end
  end

  // pulses
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      icFillVal_o <= 1'b0;
      dcFillVal_o <= 1'b0;
      stDone_o    <= 1'b0;
      invVal_o    <= 1'b0;
      wakeup_o    <= 1'b0;
      txnDone_o   <= 1'b0;
    end else begin
      icFillVal_o <= isIfill;
      dcFillVal_o <= isLoad;
      stDone_o    <= isStAck;
      invVal_o    <= isInv;
      wakeup_o    <= isInt;
      // only core-issued requests close a transaction
      txnDone_o   <= isIfill | isLoad | isStAck;
    end
  end

  // payloads, loaded only for their own return type
  always_ff @(posedge clk) begin
    if (isIfill) begin
      icFill_o.blockAddr <= l15Resp_i.addr[`BRIDGE_ADDR_WIDTH-1:IcOffBits];
      // all four words, word 0 low
      icFill_o.line      <= l15Resp_i.data;
    end
    if (isLoad) begin
      dcFill_o.blockAddr <= l15Resp_i.addr[`BRIDGE_ADDR_WIDTH-1:DcOffBits];
      // words 0 and 1 only
      dcFill_o.line      <= l15Resp_i.data[1:0];
    end
    if (isInv) begin
      invNotice_o.addr    <= l15Resp_i.addr;
      invNotice_o.icInval <= l15Resp_i.icInval;
      invNotice_o.dcInval <= l15Resp_i.dcInval;
    end
  end

endmodule
